// ==== files.f ====
logic/ecc_pkg.sv
logic/ecc_encoder.sv
logic/ecc_decoder.sv
logic/ecc_csr.sv
logic/ecc_top.sv
test/ecc_props.sv
test/ecc_tb.sv

// ==== logic/ecc_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_csr (
    input  logic                clk,
    input  logic                reset,

    input  ecc_pkg::axi_addr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  ecc_pkg::axi_word_t  wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,

    input  ecc_pkg::axi_addr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output ecc_pkg::axi_word_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,

    input  ecc_pkg::check_out_t check_out,
    output ecc_pkg::csr_ctrl_t  ctrl
);

    ecc_pkg::axi_wstate_e wstate;
    ecc_pkg::axi_rstate_e rstate;

    logic                 wr_fire;
    logic                 rd_fire;
    logic                 bypass_q;
    ecc_pkg::ecc_count_t  sbit_count;
    ecc_pkg::ecc_count_t  dbit_count;
    ecc_pkg::axi_word_t   rd_word;

    // write channel, address and data accepted together
    assign wr_fire = (wstate == ecc_pkg::WR_IDLE) & awvalid & wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bvalid  = (wstate == ecc_pkg::WR_RESP);
    assign bresp   = 2'b00; // always OKAY

    always_ff @(posedge clk) begin
        if (reset) begin
            wstate <= ecc_pkg::WR_IDLE;
        end else begin
            case (wstate)
                ecc_pkg::WR_IDLE: if (wr_fire) wstate <= ecc_pkg::WR_RESP;
                ecc_pkg::WR_RESP: if (bready) wstate <= ecc_pkg::WR_IDLE;
                default:          wstate <= ecc_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            bypass_q <= 1'b0;
        else if (wr_fire && awaddr == ecc_pkg::REG_CTRL)
            bypass_q <= wdata[0];
    end

    assign ctrl = '{bypass: bypass_q};

    // error counters, a write to the offset clears and wins over a count
    always_ff @(posedge clk) begin
        if (reset)
            sbit_count <= '0;
        else if (wr_fire && awaddr == ecc_pkg::REG_SBIT_COUNT)
            sbit_count <= '0;
        else if (check_out.valid && check_out.sbit_err && sbit_count != '1)
            sbit_count <= sbit_count + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            dbit_count <= '0;
        else if (wr_fire && awaddr == ecc_pkg::REG_DBIT_COUNT)
            dbit_count <= '0;
        else if (check_out.valid && check_out.dbit_err && dbit_count != '1)
            dbit_count <= dbit_count + 1'b1;
    end

    // read channel
    assign rd_fire = (rstate == ecc_pkg::RD_IDLE) & arvalid;
    assign arready = rd_fire;
    assign rvalid  = (rstate == ecc_pkg::RD_DATA);
    assign rresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            rstate <= ecc_pkg::RD_IDLE;
        end else begin
            case (rstate)
                ecc_pkg::RD_IDLE: if (rd_fire) rstate <= ecc_pkg::RD_DATA;
                ecc_pkg::RD_DATA: if (rready) rstate <= ecc_pkg::RD_IDLE;
                default:          rstate <= ecc_pkg::RD_IDLE;
            endcase
        end
    end

    always_comb begin
        case (araddr)
            ecc_pkg::REG_CTRL:       rd_word = {{(ecc_pkg::AXI_DATA_WIDTH-1){1'b0}}, bypass_q};
            ecc_pkg::REG_SBIT_COUNT: rd_word = ecc_pkg::axi_word_t'(sbit_count);
            ecc_pkg::REG_DBIT_COUNT: rd_word = ecc_pkg::axi_word_t'(dbit_count);
            default:                 rd_word = '0; // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            rdata <= rd_word; // held until rready
    end

endmodule

`default_nettype wire

// ==== logic/ecc_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_decoder #(
    parameter int data_width = ecc_pkg::DATA_WIDTH,
    parameter int parity_width = ecc_pkg::PARITY_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  ecc_pkg::check_in_t    check_in,
    input  ecc_pkg::csr_ctrl_t    ctrl,
    output ecc_pkg::check_out_t   check_out
);

    ecc_pkg::ecc_parity_t calc_parity;

    logic                 s1_valid;
    ecc_pkg::ecc_data_t   s1_data;
    ecc_pkg::ecc_parity_t s1_syndrome;
    logic                 s1_bypass;

    ecc_pkg::ecc_data_t   flip;      // one bit per data column match
    logic                 check_hit; // syndrome points at a check bit
    logic                 sbit;
    logic                 dbit;
    ecc_pkg::ecc_data_t   fixed_data;

    logic                 out_valid;
    ecc_pkg::ecc_data_t   out_data;
    logic                 out_sbit;
    logic                 out_dbit;

    ecc_encoder #(
        .data_width   (data_width),
        .parity_width (parity_width)
    ) u_recalc (
        .data   (check_in.data),
        .parity (calc_parity)
    );

    // stage 1: syndrome
    always_ff @(posedge clk) begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= check_in.valid;
    end

    always_ff @(posedge clk) begin
        s1_data     <= check_in.data;
        s1_syndrome <= check_in.parity ^ calc_parity;
        s1_bypass   <= ctrl.bypass; // sampled with the word
    end

    for (genvar i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin : g_match
        if (i < data_width) begin : g_col
            localparam ecc_pkg::ecc_parity_t COL = ecc_pkg::column_code(i);
            assign flip[i] = (s1_syndrome == COL);
        end else begin : g_pad
            assign flip[i] = 1'b0;
        end
    end

    assign check_hit  = $onehot(s1_syndrome);
    assign sbit       = (|flip) | check_hit;
    assign dbit       = (s1_syndrome != '0) & ~sbit;
    // a double error leaves flip at zero, so the data goes out as received
    assign fixed_data = s1_bypass ? s1_data : (s1_data ^ flip);

    // stage 2: corrected word and flags
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_sbit  <= 1'b0;
            out_dbit  <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            out_sbit  <= s1_valid & ~s1_bypass & sbit;
            out_dbit  <= s1_valid & ~s1_bypass & dbit;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= fixed_data;
    end

    assign check_out = '{
        valid:    out_valid,
        data:     out_data,
        sbit_err: out_sbit,
        dbit_err: out_dbit
    };

endmodule

`default_nettype wire

// ==== logic/ecc_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_encoder #(
    parameter int data_width = ecc_pkg::DATA_WIDTH,
    parameter int parity_width = ecc_pkg::PARITY_WIDTH
) (
    input  ecc_pkg::ecc_data_t   data,
    output ecc_pkg::ecc_parity_t parity
);

    // data bits that feed check bit j
    function automatic ecc_pkg::ecc_data_t row_mask(input int j);
        ecc_pkg::ecc_data_t mask;
        ecc_pkg::ecc_parity_t col;
        mask = '0;
        for (int i = 0; i < data_width; i++) begin
            col = ecc_pkg::column_code(i);
            mask[i] = col[j];
        end
        return mask;
    endfunction

    for (genvar j = 0; j < ecc_pkg::PARITY_WIDTH; j++) begin : g_check
        if (j < parity_width) begin : g_used
            localparam ecc_pkg::ecc_data_t ROW = row_mask(j);
            assign parity[j] = ^(data & ROW);
        end else begin : g_unused
            assign parity[j] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_WIDTH = 101;
    localparam int PARITY_WIDTH = 8;
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int COUNT_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0]     ecc_data_t;
    typedef logic [PARITY_WIDTH-1:0]   ecc_parity_t; // check bits and syndrome
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_word_t;
    typedef logic [COUNT_WIDTH-1:0]    ecc_count_t;

    typedef struct packed {
        logic        valid;
        ecc_data_t   data;
        ecc_parity_t parity;
    } check_in_t;

    typedef struct packed {
        logic      valid;
        ecc_data_t data;
        logic      sbit_err;
        logic      dbit_err;
    } check_out_t;

    // only bypass today, more control bits go here
    typedef struct packed {
        logic bypass;
    } csr_ctrl_t;

    typedef enum logic {WR_IDLE, WR_RESP} axi_wstate_e;
    typedef enum logic {RD_IDLE, RD_DATA} axi_rstate_e;

    localparam axi_addr_t REG_CTRL       = 8'h00;
    localparam axi_addr_t REG_SBIT_COUNT = 8'h04;
    localparam axi_addr_t REG_DBIT_COUNT = 8'h08;

    // column of data bit i: low bits take the i-th value >= 3 that is not
    // a power of two, top bit makes the column weight odd
    function automatic ecc_parity_t column_code(input int unsigned i);
        ecc_parity_t code;
        int unsigned seen;
        code = '0;
        seen = 0;
        for (int unsigned v = 3; v < 2**(PARITY_WIDTH-1); v++) begin
            if (!$onehot(v)) begin
                if (seen == i)
                    code[PARITY_WIDTH-2:0] = v[PARITY_WIDTH-2:0];
                seen++;
            end
        end
        code[PARITY_WIDTH-1] = ~^code[PARITY_WIDTH-2:0];
        return code;
    endfunction

endpackage

`default_nettype wire

// ==== logic/ecc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_top #(
    parameter int data_width = ecc_pkg::DATA_WIDTH,
    parameter int parity_width = ecc_pkg::PARITY_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,

    input  ecc_pkg::ecc_data_t   data_in,
    output ecc_pkg::ecc_parity_t parity_out,

    input  ecc_pkg::check_in_t   check_in,
    output ecc_pkg::check_out_t  check_out,

    input  ecc_pkg::axi_addr_t   awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  ecc_pkg::axi_word_t   wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  ecc_pkg::axi_addr_t   araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output ecc_pkg::axi_word_t   rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    ecc_pkg::csr_ctrl_t ctrl;

    ecc_encoder #(
        .data_width   (data_width),
        .parity_width (parity_width)
    ) u_encoder (
        .data   (data_in),
        .parity (parity_out)
    );

    ecc_decoder #(
        .data_width   (data_width),
        .parity_width (parity_width)
    ) u_decoder (
        .clk       (clk),
        .reset     (reset),
        .check_in  (check_in),
        .ctrl      (ctrl),
        .check_out (check_out)
    );

    ecc_csr u_csr (
        .clk       (clk),
        .reset     (reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .check_out (check_out), // counts flags of the decoder output
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the ECC testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ecc_tb -f files.f -o ecc_sim

if ! sim_out="$(./obj_dir/ecc_sim 2>&1)"; then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_out"

if grep -qx "Verification passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== test/ecc_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_props (
    input logic                clk,
    input logic                reset,
    input logic                in_valid,
    input logic                bypass,
    input ecc_pkg::check_out_t check_out,
    input logic                bvalid,
    input logic                bready,
    input logic                rvalid,
    input logic                rready
);

    a_one_flag: assert property (@(posedge clk) disable iff (reset)
        !(check_out.sbit_err && check_out.dbit_err))
        else $error("sbit_err and dbit_err high together");

    a_bypass_quiet: assert property (@(posedge clk) disable iff (reset)
        check_out.valid && $past(bypass, 2) |-> !check_out.sbit_err && !check_out.dbit_err)
        else $error("error flag raised on a bypassed word");

    // two register stages between input and output
    a_latency: assert property (@(posedge clk) disable iff (reset)
        check_out.valid == $past(in_valid, 2))
        else $error("output valid does not follow input valid by 2 cycles");

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind ecc_decoder ecc_props u_dec_props (
    .clk (clk), .reset (reset), .in_valid (check_in.valid), .bypass (ctrl.bypass),
    .check_out (check_out),
    .bvalid (1'b0), .bready (1'b0), .rvalid (1'b0), .rready (1'b0)
);

bind ecc_csr ecc_props u_csr_props (
    .clk (clk), .reset (reset), .in_valid (1'b0), .bypass (1'b0), .check_out ('0),
    .bvalid (bvalid), .bready (bready), .rvalid (rvalid), .rready (rready)
);

`default_nettype wire

// ==== test/ecc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_tb;

    typedef struct packed {
        ecc_pkg::ecc_data_t data;
        logic               sbit_err;
        logic               dbit_err;
    } result_t;

    localparam int MAX_VECTORS = 64;

    logic                 clk;
    logic                 reset;
    ecc_pkg::ecc_data_t   data_in;
    ecc_pkg::ecc_parity_t parity_out;
    ecc_pkg::check_in_t   check_in;
    ecc_pkg::check_out_t  check_out;
    ecc_pkg::axi_addr_t   awaddr;
    logic                 awvalid;
    logic                 awready;
    ecc_pkg::axi_word_t   wdata;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    ecc_pkg::axi_addr_t   araddr;
    logic                 arvalid;
    logic                 arready;
    ecc_pkg::axi_word_t   rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;

    ecc_pkg::ecc_parity_t col_table [ecc_pkg::DATA_WIDTH];
    logic [ecc_pkg::DATA_WIDTH-1:0] vec_mem [0:4*MAX_VECTORS]; // count, then 4 words per vector
    result_t expect_q [$];
    string   name_q [$];
    int      vec_count;
    int      error_count;
    int      check_count;
    int      exp_sbit_count;
    int      exp_dbit_count;

    ecc_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .parity_out (parity_out),
        .check_in   (check_in),
        .check_out  (check_out),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    always #10 clk = ~clk;

    // i-th integer from 3 up that is not a power of two, top bit gives odd weight
    function automatic ecc_pkg::ecc_parity_t column_of(input int i);
        int v;
        int n;
        ecc_pkg::ecc_parity_t col;
        v = 2;
        n = -1;
        while (n < i) begin
            v++;
            if ((v & (v - 1)) != 0)
                n++;
        end
        col[6:0] = v[6:0];
        col[7]   = ~^v[6:0];
        return col;
    endfunction

    function automatic ecc_pkg::ecc_parity_t model_parity(input ecc_pkg::ecc_data_t d);
        ecc_pkg::ecc_parity_t p;
        p = '0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (d[i])
                p = p ^ col_table[i];
        end
        return p;
    endfunction

    task automatic compare_values(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic send_word(input string name, input ecc_pkg::ecc_data_t clean,
                             input ecc_pkg::check_in_t word, input result_t expected);
        @(negedge clk);
        data_in  = clean;
        check_in = word;
        expect_q.push_back(expected);
        name_q.push_back(name);
        @(posedge clk);
        compare_values({name, " parity"}, 128'(model_parity(clean)), 128'(parity_out));
    endtask

    task automatic drain_pipeline;
        @(negedge clk);
        check_in.valid = 1'b0;
        while (expect_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic axi_write(input ecc_pkg::axi_addr_t addr, input ecc_pkg::axi_word_t word);
        @(negedge clk);
        awaddr  = addr;
        wdata   = word;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        compare_values("write ready", 128'(2'b11), 128'({awready, wready}));
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        compare_values("write ready pulse", 128'(2'b00), 128'({awready, wready}));
        awvalid = 1'b0;
        wvalid  = 1'b0;
        compare_values("write bresp", 128'(2'b00), 128'(bresp));
        @(negedge clk); // response left waiting one cycle
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input ecc_pkg::axi_addr_t addr, output ecc_pkg::axi_word_t word);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        compare_values("read arready", 128'(1'b1), 128'(arready));
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        compare_values("read arready pulse", 128'(1'b0), 128'(arready));
        arvalid = 1'b0;
        word    = rdata;
        compare_values("read rresp", 128'(2'b00), 128'(rresp));
        @(negedge clk); // data left waiting one cycle
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    always @(negedge clk) begin : output_monitor
        result_t expected;
        string   name;
        if (!reset && check_out.valid) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("ERROR: decoder put out a word that was never sent");
            end else begin
                expected = expect_q.pop_front();
                name     = name_q.pop_front();
                compare_values({name, " data"}, 128'(expected.data), 128'(check_out.data));
                compare_values({name, " flags"}, 128'({expected.sbit_err, expected.dbit_err}),
                               128'({check_out.sbit_err, check_out.dbit_err}));
            end
        end
    end

    initial begin : main
        ecc_pkg::ecc_data_t   word;
        ecc_pkg::ecc_data_t   rx_data;
        ecc_pkg::ecc_parity_t rx_parity;
        ecc_pkg::check_in_t   word_in;
        ecc_pkg::axi_word_t   rd;
        logic [127:0]         rnd;
        logic                 bypass_now;
        logic                 bypass_flag;
        int                   pos [2];
        int                   flips;
        int                   cbit;
        result_t              expected;

        clk     = 1'b0;
        reset   = 1'b1;
        data_in = '0;
        check_in = '0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        error_count    = 0;
        check_count    = 0;
        exp_sbit_count = 0;
        exp_dbit_count = 0;
        bypass_now     = 1'b0;
        void'($urandom(32'he9f0));
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++)
            col_table[i] = column_of(i);
        $readmemh("test/ecc_testdata.txt", vec_mem);
        vec_count = int'(vec_mem[0][15:0]);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < vec_count; k++) begin
            word        = vec_mem[4*k+1];
            pos[0]      = int'(vec_mem[4*k+2][7:0]);
            pos[1]      = int'(vec_mem[4*k+3][7:0]);
            bypass_flag = vec_mem[4*k+4][0];
            if (bypass_flag != bypass_now) begin
                drain_pipeline(); // bypass is taken with each word, so flush first
                axi_write(ecc_pkg::REG_CTRL, {31'b0, bypass_flag});
                bypass_now = bypass_flag;
            end
            rx_data   = word;
            rx_parity = model_parity(word);
            flips     = 0;
            foreach (pos[j]) begin
                if (pos[j] < ecc_pkg::DATA_WIDTH) begin
                    rx_data[pos[j]] = ~rx_data[pos[j]];
                    flips++;
                end else if (pos[j] < ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH) begin
                    cbit            = pos[j] - ecc_pkg::DATA_WIDTH;
                    rx_parity[cbit] = ~rx_parity[cbit];
                    flips++;
                end
            end
            expected = '{data: word, sbit_err: 1'b0, dbit_err: 1'b0};
            if (bypass_now) begin
                expected.data = rx_data;
            end else if (flips == 1) begin
                expected.sbit_err = 1'b1;
                exp_sbit_count++;
            end else if (flips == 2) begin
                expected.data     = rx_data; // detected, not corrected
                expected.dbit_err = 1'b1;
                exp_dbit_count++;
            end
            word_in = '{valid: 1'b1, data: rx_data, parity: rx_parity};
            send_word($sformatf("vector %0d", k), word, word_in, expected);

            rnd      = {$urandom, $urandom, $urandom, $urandom};
            word     = rnd[ecc_pkg::DATA_WIDTH-1:0];
            word_in  = '{valid: 1'b1, data: word, parity: model_parity(word)};
            expected = '{data: word, sbit_err: 1'b0, dbit_err: 1'b0};
            send_word($sformatf("filler %0d", k), word, word_in, expected);
        end
        drain_pipeline();

        axi_read(ecc_pkg::REG_CTRL, rd);
        compare_values("ctrl register", 128'({31'b0, bypass_now}), 128'(rd));
        axi_read(ecc_pkg::REG_SBIT_COUNT, rd);
        compare_values("sbit count", 128'(exp_sbit_count), 128'(rd));
        axi_read(ecc_pkg::REG_DBIT_COUNT, rd);
        compare_values("dbit count", 128'(exp_dbit_count), 128'(rd));
        axi_write(ecc_pkg::REG_SBIT_COUNT, '0);
        axi_read(ecc_pkg::REG_SBIT_COUNT, rd);
        compare_values("sbit count cleared", 128'(0), 128'(rd));
        axi_write(ecc_pkg::REG_DBIT_COUNT, '0);
        axi_read(ecc_pkg::REG_DBIT_COUNT, rd);
        compare_values("dbit count cleared", 128'(0), 128'(rd));
        axi_read(8'h0c, rd);
        compare_values("unmapped read", 128'(0), 128'(rd));

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        #1;
        limit_ns = (vec_count + 100) * 40 * 20;
        #(limit_ns);
        $display("watchdog: run timed out after %0d ns without finishing", limit_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ecc_testdata.txt ====
// columns: data word (101 bits), flip position a, flip position b, bypass flag, all in hex
// flip positions 00-64 are data bits, 65-6c are check bits 0-7, ff means no flip
// first value is the number of vectors
22
00000000000000000000000000 ff ff 0
1fffffffffffffffffffffffff ff ff 0
123456789abcdef0123456789a ff ff 0
123456789abcdef0123456789a 00 ff 0
0deadbeef0123456789abcdef0 64 ff 0
1a5a5a5a5a5a5a5a5a5a5a5a5a ff 32 0
05a5a5a5a5a5a5a5a5a5a5a5a5 1f ff 0
13579bdf02468ace13579bdf02 4b ff 0
0fedcba98765432100fedcba98 07 ff 0
10f0f0f0f0f0f0f0f0f0f0f0f0 65 ff 0
0c0ffee1234face0b00c577e11 66 ff 0
00000000000000000000000000 69 ff 0
1fffffffffffffffffffffffff 6c ff 0
0deadbeef0123456789abcdef0 ff 6a 0
123456789abcdef0123456789a 00 01 0
1a5a5a5a5a5a5a5a5a5a5a5a5a 10 63 0
05a5a5a5a5a5a5a5a5a5a5a5a5 64 65 0
13579bdf02468ace13579bdf02 65 6c 0
0fedcba98765432100fedcba98 2a 6b 0
00000000000000000000000000 05 06 0
1fffffffffffffffffffffffff 40 41 0
0c0ffee1234face0b00c577e11 ff ff 0
0deadbeef0123456789abcdef0 11 ff 1
1a5a5a5a5a5a5a5a5a5a5a5a5a 12 34 1
05a5a5a5a5a5a5a5a5a5a5a5a5 66 ff 1
10f0f0f0f0f0f0f0f0f0f0f0f0 ff ff 1
13579bdf02468ace13579bdf02 64 00 1
0fedcba98765432100fedcba98 21 ff 0
10f0f0f0f0f0f0f0f0f0f0f0f0 22 55 0
0c0ffee1234face0b00c577e11 67 ff 0
123456789abcdef0123456789a 3c ff 0
0deadbeef0123456789abcdef0 ff ff 0
1a5a5a5a5a5a5a5a5a5a5a5a5a 5d 6c 0
05a5a5a5a5a5a5a5a5a5a5a5a5 0e ff 0
